//--- hdl/cpu_pkg.sv
package cpu_pkg;

    localparam int DATA_W     = 32;
    localparam int INST_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int REG_NUM    = 32;
    localparam int SHAMT_W    = 5;
    localparam int ALU_OP_W   = 4;
    localparam int WB_ADR_W   = 6;

    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [INST_W-1:0]     inst_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [SHAMT_W-1:0]    shamt_t;
    typedef logic [ALU_OP_W-1:0]   alu_op_t;
    typedef logic [WB_ADR_W-1:0]   wb_adr_t;

    typedef enum logic {
        WB_IDLE,
        WB_ACK
    } wb_state_e;

    // Major opcodes, instruction bits 31:26
    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_ADDI    = 6'b001000;
    localparam logic [5:0] OP_ADDIU   = 6'b001001;
    localparam logic [5:0] OP_SLTI    = 6'b001010;
    localparam logic [5:0] OP_SLTIU   = 6'b001011;
    localparam logic [5:0] OP_ANDI    = 6'b001100;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_XORI    = 6'b001110;
    localparam logic [5:0] OP_LUI     = 6'b001111;

    // Function codes of the SPECIAL group, instruction bits 5:0
    localparam logic [5:0] FN_SLL  = 6'b000000;
    localparam logic [5:0] FN_SRL  = 6'b000010;
    localparam logic [5:0] FN_SRA  = 6'b000011;
    localparam logic [5:0] FN_SLLV = 6'b000100;
    localparam logic [5:0] FN_SRLV = 6'b000110;
    localparam logic [5:0] FN_SRAV = 6'b000111;
    localparam logic [5:0] FN_ADD  = 6'b100000;
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUB  = 6'b100010;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_NOR  = 6'b100111;
    localparam logic [5:0] FN_SLT  = 6'b101010;
    localparam logic [5:0] FN_SLTU = 6'b101011;

    // ALU operations, signed and unsigned add and sub share one code
    localparam alu_op_t ALU_NOP  = 4'd0;
    localparam alu_op_t ALU_OR   = 4'd1;
    localparam alu_op_t ALU_AND  = 4'd2;
    localparam alu_op_t ALU_XOR  = 4'd3;
    localparam alu_op_t ALU_NOR  = 4'd4;
    localparam alu_op_t ALU_SLL  = 4'd5;
    localparam alu_op_t ALU_SRL  = 4'd6;
    localparam alu_op_t ALU_SRA  = 4'd7;
    localparam alu_op_t ALU_ADD  = 4'd8;
    localparam alu_op_t ALU_SUB  = 4'd9;
    localparam alu_op_t ALU_SLT  = 4'd10;
    localparam alu_op_t ALU_SLTU = 4'd11;

    localparam data_t ZERO_WORD = '0;

    // Bus map
    localparam wb_adr_t INST_ADR    = 6'd0;
    localparam int      REG_ADR_BIT = 5;        // Set for register reads, low bits pick the register

endpackage

//--- hdl/exec_unit.sv
`timescale 1ns/100ps

module exec_unit (
    input  logic               valid_i,
    input  cpu_pkg::alu_op_t   aluop_i,
    input  cpu_pkg::data_t     reg1_i,
    input  cpu_pkg::data_t     reg2_i,
    input  cpu_pkg::reg_addr_t wd_i,
    input  logic               wreg_i,
    output logic               ex_wreg_o,
    output cpu_pkg::reg_addr_t ex_wd_o,
    output cpu_pkg::data_t     ex_wdata_o
);
    import cpu_pkg::*;

    shamt_t shamt;
    data_t  result;

    assign shamt = reg1_i[SHAMT_W-1:0];    // Only the low five bits count

    always_comb begin
        case (aluop_i)
            ALU_OR: begin
                result = reg1_i | reg2_i;
            end
            ALU_AND: begin
                result = reg1_i & reg2_i;
            end
            ALU_XOR: begin
                result = reg1_i ^ reg2_i;
            end
            ALU_NOR: begin
                result = ~(reg1_i | reg2_i);
            end
            ALU_SLL: begin
                result = reg2_i << shamt;
            end
            ALU_SRL: begin
                result = reg2_i >> shamt;
            end
            ALU_SRA: begin
                result = data_t'($signed(reg2_i) >>> shamt);
            end
            ALU_ADD: begin
                result = reg1_i + reg2_i;     // Wraps, no overflow trap
            end
            ALU_SUB: begin
                result = reg1_i - reg2_i;
            end
            ALU_SLT: begin
                result = data_t'($signed(reg1_i) < $signed(reg2_i));
            end
            ALU_SLTU: begin
                result = data_t'(reg1_i < reg2_i);
            end
            default: begin
                result = ZERO_WORD;
            end
        endcase
    end

    // Feeds both the register file write port and the decoder bypass
    assign ex_wreg_o  = valid_i && wreg_i;
    assign ex_wd_o    = wd_i;
    assign ex_wdata_o = result;

endmodule

//--- hdl/id_ex_reg.sv
`timescale 1ns/100ps

module id_ex_reg (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               valid_i,
    input  cpu_pkg::alu_op_t   aluop_i,
    input  cpu_pkg::data_t     reg1_i,
    input  cpu_pkg::data_t     reg2_i,
    input  cpu_pkg::reg_addr_t wd_i,
    input  logic               wreg_i,
    output logic               valid_o,
    output cpu_pkg::alu_op_t   aluop_o,
    output cpu_pkg::data_t     reg1_o,
    output cpu_pkg::data_t     reg2_o,
    output cpu_pkg::reg_addr_t wd_o,
    output logic               wreg_o
);

    // Valid tracks the issue strobe so an idle cycle drains the stage
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
            wreg_o  <= 1'b0;
        end else begin
            valid_o <= valid_i;
            wreg_o  <= wreg_i;
        end
    end

    always_ff @(posedge clk_i) begin
        aluop_o <= aluop_i;
        reg1_o  <= reg1_i;   // Operands already carry any forwarded value
        reg2_o  <= reg2_i;
        wd_o    <= wd_i;
    end

endmodule

//--- hdl/inst_decoder.sv
`timescale 1ns/100ps

module inst_decoder (
    input  logic               inst_valid_i,
    input  cpu_pkg::inst_t     inst_i,
    input  cpu_pkg::data_t     reg1_data_i,
    input  cpu_pkg::data_t     reg2_data_i,
    input  logic               ex_wreg_i,
    input  cpu_pkg::reg_addr_t ex_wd_i,
    input  cpu_pkg::data_t     ex_wdata_i,
    output cpu_pkg::reg_addr_t reg1_addr_o,
    output cpu_pkg::reg_addr_t reg2_addr_o,
    output cpu_pkg::alu_op_t   aluop_o,
    output cpu_pkg::data_t     reg1_o,
    output cpu_pkg::data_t     reg2_o,
    output cpu_pkg::reg_addr_t wd_o,
    output logic               wreg_o
);
    import cpu_pkg::*;

    logic [5:0] op;
    logic [5:0] funct;
    reg_addr_t  rs;
    reg_addr_t  rt;
    reg_addr_t  rd;
    shamt_t     sa;
    logic [15:0] imm16;
    data_t      imm;
    logic       reg1_read;
    logic       reg2_read;

    assign op    = inst_i[31:26];
    assign rs    = inst_i[25:21];
    assign rt    = inst_i[20:16];
    assign rd    = inst_i[15:11];
    assign sa    = inst_i[10:6];
    assign funct = inst_i[5:0];
    assign imm16 = inst_i[15:0];

    assign reg1_addr_o = rs;
    assign reg2_addr_o = rt;

    // The execute result wins over the register file, the immediate is used when nothing is read
    function automatic data_t pick_operand(input logic rd_en, input reg_addr_t addr,
                                           input data_t rf_data, input data_t imm_val,
                                           input logic fwd_en, input reg_addr_t fwd_addr,
                                           input data_t fwd_data);
        if (rd_en && fwd_en && (fwd_addr == addr)) begin
            return fwd_data;
        end else if (rd_en) begin
            return rf_data;
        end
        return imm_val;
    endfunction

    always_comb begin
        aluop_o   = ALU_NOP;
        wd_o      = rd;
        reg1_read = 1'b0;
        reg2_read = 1'b0;
        imm       = ZERO_WORD;
        case (op)
            OP_SPECIAL: begin
                reg1_read = 1'b1;
                reg2_read = 1'b1;
                case (funct)
                    FN_SLL:          aluop_o = ALU_SLL;
                    FN_SRL:          aluop_o = ALU_SRL;
                    FN_SRA:          aluop_o = ALU_SRA;
                    FN_SLLV:         aluop_o = ALU_SLL;
                    FN_SRLV:         aluop_o = ALU_SRL;
                    FN_SRAV:         aluop_o = ALU_SRA;
                    FN_OR:           aluop_o = ALU_OR;
                    FN_AND:          aluop_o = ALU_AND;
                    FN_XOR:          aluop_o = ALU_XOR;
                    FN_NOR:          aluop_o = ALU_NOR;
                    FN_ADD, FN_ADDU: aluop_o = ALU_ADD;
                    FN_SUB, FN_SUBU: aluop_o = ALU_SUB;
                    FN_SLT:          aluop_o = ALU_SLT;
                    FN_SLTU:         aluop_o = ALU_SLTU;
                    default:         aluop_o = ALU_NOP;
                endcase
                if ((funct == FN_SLL) || (funct == FN_SRL) || (funct == FN_SRA)) begin
                    reg1_read = 1'b0;           // Shift amount comes from the sa field
                    imm[SHAMT_W-1:0] = sa;
                    if (rs != '0) begin
                        aluop_o = ALU_NOP;
                    end
                end else if (sa != '0) begin
                    aluop_o = ALU_NOP;
                end
            end
            OP_ORI, OP_ANDI, OP_XORI: begin
                reg1_read = 1'b1;
                wd_o      = rt;
                imm       = {16'h0, imm16};
                aluop_o   = (op == OP_ORI) ? ALU_OR : (op == OP_ANDI) ? ALU_AND : ALU_XOR;
            end
            OP_LUI: begin
                wd_o    = rt;
                imm     = {imm16, 16'h0};   // Both operands carry the immediate
                aluop_o = ALU_OR;
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU: begin
                reg1_read = 1'b1;
                wd_o      = rt;
                imm       = {{16{imm16[15]}}, imm16};
                aluop_o   = (op == OP_SLTI) ? ALU_SLT : (op == OP_SLTIU) ? ALU_SLTU : ALU_ADD;
            end
            default: begin
            end
        endcase
    end

    assign wreg_o = inst_valid_i && (aluop_o != ALU_NOP) && (wd_o != '0);

    assign reg1_o = pick_operand(reg1_read, rs, reg1_data_i, imm, ex_wreg_i, ex_wd_i, ex_wdata_i);
    assign reg2_o = pick_operand(reg2_read, rt, reg2_data_i, imm, ex_wreg_i, ex_wd_i, ex_wdata_i);

endmodule

//--- hdl/mips_core_top.sv
`timescale 1ns/100ps

module mips_core_top (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             wb_cyc_i,
    input  logic             wb_stb_i,
    input  logic             wb_we_i,
    input  cpu_pkg::wb_adr_t wb_adr_i,
    input  cpu_pkg::data_t   wb_dat_i,
    output cpu_pkg::data_t   wb_dat_o,
    output logic             wb_ack_o
);
    import cpu_pkg::*;

    logic      inst_valid;
    inst_t     inst;
    reg_addr_t bus_rd_addr;
    data_t     bus_rd_data;

    reg_addr_t reg1_addr;
    reg_addr_t reg2_addr;
    data_t     reg1_data;
    data_t     reg2_data;

    // Decode stage outputs
    alu_op_t   id_aluop;
    data_t     id_reg1;
    data_t     id_reg2;
    reg_addr_t id_wd;
    logic      id_wreg;

    // Execute stage inputs
    logic      ex_valid;
    alu_op_t   ex_aluop;
    data_t     ex_reg1;
    data_t     ex_reg2;
    reg_addr_t ex_wd_in;
    logic      ex_wreg_in;

    logic      ex_wreg;
    reg_addr_t ex_wd;
    data_t     ex_wdata;

    wb_slave u_wb_slave (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .wb_cyc_i     (wb_cyc_i),
        .wb_stb_i     (wb_stb_i),
        .wb_we_i      (wb_we_i),
        .wb_adr_i     (wb_adr_i),
        .wb_dat_i     (wb_dat_i),
        .rd_data_i    (bus_rd_data),
        .wb_dat_o     (wb_dat_o),
        .wb_ack_o     (wb_ack_o),
        .inst_valid_o (inst_valid),
        .inst_o       (inst),
        .rd_addr_o    (bus_rd_addr)
    );

    inst_decoder u_inst_decoder (
        .inst_valid_i (inst_valid),
        .inst_i       (inst),
        .reg1_data_i  (reg1_data),
        .reg2_data_i  (reg2_data),
        .ex_wreg_i    (ex_wreg),
        .ex_wd_i      (ex_wd),
        .ex_wdata_i   (ex_wdata),
        .reg1_addr_o  (reg1_addr),
        .reg2_addr_o  (reg2_addr),
        .aluop_o      (id_aluop),
        .reg1_o       (id_reg1),
        .reg2_o       (id_reg2),
        .wd_o         (id_wd),
        .wreg_o       (id_wreg)
    );

    reg_file u_reg_file (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .we_i     (ex_wreg),
        .waddr_i  (ex_wd),
        .wdata_i  (ex_wdata),
        .raddr1_i (reg1_addr),
        .raddr2_i (reg2_addr),
        .raddr3_i (bus_rd_addr),
        .rdata1_o (reg1_data),
        .rdata2_o (reg2_data),
        .rdata3_o (bus_rd_data)
    );

    id_ex_reg u_id_ex_reg (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .valid_i (inst_valid),
        .aluop_i (id_aluop),
        .reg1_i  (id_reg1),
        .reg2_i  (id_reg2),
        .wd_i    (id_wd),
        .wreg_i  (id_wreg),
        .valid_o (ex_valid),
        .aluop_o (ex_aluop),
        .reg1_o  (ex_reg1),
        .reg2_o  (ex_reg2),
        .wd_o    (ex_wd_in),
        .wreg_o  (ex_wreg_in)
    );

    exec_unit u_exec_unit (
        .valid_i    (ex_valid),
        .aluop_i    (ex_aluop),
        .reg1_i     (ex_reg1),
        .reg2_i     (ex_reg2),
        .wd_i       (ex_wd_in),
        .wreg_i     (ex_wreg_in),
        .ex_wreg_o  (ex_wreg),
        .ex_wd_o    (ex_wd),
        .ex_wdata_o (ex_wdata)
    );

endmodule

//--- hdl/reg_file.sv
`timescale 1ns/100ps

module reg_file (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               we_i,
    input  cpu_pkg::reg_addr_t waddr_i,
    input  cpu_pkg::data_t     wdata_i,
    input  cpu_pkg::reg_addr_t raddr1_i,
    input  cpu_pkg::reg_addr_t raddr2_i,
    input  cpu_pkg::reg_addr_t raddr3_i,
    output cpu_pkg::data_t     rdata1_o,
    output cpu_pkg::data_t     rdata2_o,
    output cpu_pkg::data_t     rdata3_o
);
    import cpu_pkg::*;

    data_t regs [REG_NUM];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < REG_NUM; i++) begin
                regs[i] <= ZERO_WORD;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // Register 0 is hardwired to zero
    function automatic data_t read_reg(input reg_addr_t addr);
        return (addr == '0) ? ZERO_WORD : regs[addr];
    endfunction

    assign rdata1_o = read_reg(raddr1_i);
    assign rdata2_o = read_reg(raddr2_i);
    assign rdata3_o = read_reg(raddr3_i);  // Bus read port

endmodule

//--- hdl/wb_slave.sv
`timescale 1ns/100ps

module wb_slave (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               wb_cyc_i,
    input  logic               wb_stb_i,
    input  logic               wb_we_i,
    input  cpu_pkg::wb_adr_t   wb_adr_i,
    input  cpu_pkg::inst_t     wb_dat_i,
    input  cpu_pkg::data_t     rd_data_i,
    output cpu_pkg::data_t     wb_dat_o,
    output logic               wb_ack_o,
    output logic               inst_valid_o,
    output cpu_pkg::inst_t     inst_o,
    output cpu_pkg::reg_addr_t rd_addr_o
);
    import cpu_pkg::*;

    wb_state_e state_q;
    wb_state_e state_d;
    logic      reg_read;

    always_comb begin
        state_d = state_q;
        case (state_q)
            WB_IDLE: begin
                if (wb_cyc_i && wb_stb_i) begin
                    state_d = WB_ACK;
                end
            end
            default: begin
                state_d = WB_IDLE;  // Ack lasts one cycle, then wait for a fresh strobe
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= WB_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign wb_ack_o = (state_q == WB_ACK) && wb_cyc_i && wb_stb_i;

    assign inst_valid_o = wb_ack_o && wb_we_i && (wb_adr_i == INST_ADR);
    assign inst_o       = wb_dat_i;

    assign reg_read  = wb_ack_o && !wb_we_i && wb_adr_i[REG_ADR_BIT];
    assign rd_addr_o = wb_adr_i[REG_ADDR_W-1:0];
    assign wb_dat_o  = reg_read ? rd_data_i : ZERO_WORD;  // Other reads return zero

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f sim.f --top-module tb_mips_core -Mdir "$BUILD_DIR" -o sim_mips_core
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/sim_mips_core" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "TEST RESULT: PASS" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

//--- sim.f
hdl/cpu_pkg.sv
hdl/wb_slave.sv
hdl/inst_decoder.sv
hdl/reg_file.sv
hdl/id_ex_reg.sv
hdl/exec_unit.sv
hdl/mips_core_top.sv
testbench/mips_core_props.sv
testbench/tb_mips_core.sv

//--- testbench/mips_core_props.sv
`timescale 1ns/100ps

module mips_core_props (
    input logic clk_i,
    input logic rst_n_i,
    input logic cyc_i,
    input logic stb_i,
    input logic ack_i
);

    // A held strobe is answered in the very next cycle
    ack_next_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (cyc_i && stb_i && !ack_i) |=> ack_i)
    else $error("wb_ack_o missing in the cycle after a strobe was seen");

    ack_single_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ack_i |=> !ack_i)
    else $error("wb_ack_o high in two consecutive cycles");

    ack_low_after_reset: assert property (@(posedge clk_i)
        $rose(rst_n_i) |-> !ack_i)
    else $error("wb_ack_o high in the first cycle after reset");

endmodule

bind mips_core_top mips_core_props u_props (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .cyc_i   (wb_cyc_i),
    .stb_i   (wb_stb_i),
    .ack_i   (wb_ack_o)
);

//--- testbench/tb_mips_core.sv
`timescale 1ns/100ps

module tb_mips_core;
    import cpu_pkg::*;

    localparam int MAX_CYCLES = 6000;   // Several times what all bus accesses of the run need
    localparam logic [5:0] R_FNS [10] = '{FN_OR, FN_AND, FN_XOR, FN_NOR, FN_ADD,
                                          FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_SLTU};
    localparam logic [5:0] I_OPS [7] = '{OP_ORI, OP_ANDI, OP_XORI, OP_ADDI,
                                         OP_ADDIU, OP_SLTI, OP_SLTIU};
    localparam logic [5:0] SH_FNS [6] = '{FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV};

    logic        clk_i;
    logic        rst_n_i;
    logic        wb_cyc_i;
    logic        wb_stb_i;
    logic        wb_we_i;
    wb_adr_t     wb_adr_i;
    data_t       wb_dat_i;
    data_t       wb_dat_o;
    logic        wb_ack_o;

    data_t       shadow [32];
    logic [31:0] lfsr_state = 32'heefa_35ce;
    int unsigned cycle_cnt = 0;
    int unsigned check_cnt = 0;
    int unsigned err_cnt = 0;

    mips_core_top i_dut (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Run timed out after %0d cycles before all tests were done", cycle_cnt);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            val = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic reg_addr_t pick_reg();
        reg_addr_t r;
        r = reg_addr_t'(take_bits(5));
        return (r == '0) ? 5'd1 : r;
    endfunction

    function automatic inst_t encode_r(input logic [5:0] fn, input reg_addr_t rs,
                                       input reg_addr_t rt, input reg_addr_t rd,
                                       input shamt_t sa);
        return {OP_SPECIAL, rs, rt, rd, sa, fn};
    endfunction

    function automatic inst_t encode_i(input logic [5:0] op, input reg_addr_t rs,
                                       input reg_addr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Reference behavior of one instruction on the shadow registers
    function automatic void apply_model(input inst_t inst);
        logic [5:0] op;
        logic [5:0] fn;
        reg_addr_t  dst;
        data_t      a;
        data_t      b;
        data_t      sext;
        data_t      res;
        logic [4:0] sh;
        logic       wr;
        op   = inst[31:26];
        fn   = inst[5:0];
        a    = shadow[inst[25:21]];
        b    = shadow[inst[20:16]];
        sext = {{16{inst[15]}}, inst[15:0]};
        dst  = (op == OP_SPECIAL) ? inst[15:11] : inst[20:16];
        sh   = fn[2] ? a[4:0] : inst[10:6];     // Variable shifts use rs, the others sa
        wr   = 1'b1;
        res  = '0;
        case (op)
            OP_SPECIAL: begin
                case (fn)
                    FN_SLL, FN_SLLV: res = b << sh;
                    FN_SRL, FN_SRLV: res = b >> sh;
                    FN_SRA, FN_SRAV: res = (b >> sh) | (b[31] ? ~(32'hffff_ffff >> sh) : '0);
                    FN_OR:           res = a | b;
                    FN_AND:          res = a & b;
                    FN_XOR:          res = a ^ b;
                    FN_NOR:          res = ~(a | b);
                    FN_ADD, FN_ADDU: res = a + b;
                    FN_SUB, FN_SUBU: res = a - b;
                    FN_SLT:          res = {31'd0, $signed(a) < $signed(b)};
                    FN_SLTU:         res = {31'd0, a < b};
                    default:         wr = 1'b0;
                endcase
            end
            OP_ORI:            res = a | {16'h0, inst[15:0]};
            OP_ANDI:           res = a & {16'h0, inst[15:0]};
            OP_XORI:           res = a ^ {16'h0, inst[15:0]};
            OP_LUI:            res = {inst[15:0], 16'h0};
            OP_ADDI, OP_ADDIU: res = a + sext;
            OP_SLTI:           res = {31'd0, $signed(a) < $signed(sext)};
            OP_SLTIU:          res = {31'd0, a < sext};
            default:           wr = 1'b0;
        endcase
        if (wr && (dst != '0)) begin
            shadow[dst] = res;
        end
    endfunction

    // Classic cycle, entered and left 2 ns after a rising edge
    task automatic bus_access(input logic we, input wb_adr_t adr, input data_t dat,
                              output data_t rdata);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = dat;
        @(negedge clk_i);
        while (!wb_ack_o) begin
            @(negedge clk_i);
        end
        rdata = wb_dat_o;
        @(posedge clk_i);
        #2;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    task automatic issue(input inst_t inst);
        data_t unused;
        bus_access(1'b1, INST_ADR, inst, unused);
        apply_model(inst);
    endtask

    task automatic check_reg(input reg_addr_t r);
        data_t got;
        bus_access(1'b0, wb_adr_t'({1'b1, r}), ZERO_WORD, got);
        check_cnt++;
        assert (got == shadow[r]) else begin
            err_cnt++;
            $display("** Error at %0t: register %0d expected %h, got %h",
                     $time, r, shadow[r], got);
        end
    endtask

    task automatic check_all();
        for (int r = 0; r < 32; r++) begin
            check_reg(reg_addr_t'(r));
        end
    endtask

    task automatic load_random_words();
        data_t word;
        for (int r = 1; r < 32; r++) begin
            word = take_bits(32);
            issue(encode_i(OP_LUI, '0, reg_addr_t'(r), word[31:16]));
            issue(encode_i(OP_ORI, reg_addr_t'(r), reg_addr_t'(r), word[15:0]));
        end
        check_all();
    endtask

    task automatic run_alu_ops();
        logic [5:0]  code;
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   rd;
        logic [15:0] imm;
        for (int n = 0; n < 60; n++) begin
            code = R_FNS[int'(take_bits(4) % 10)];
            rs   = reg_addr_t'(take_bits(5));
            rt   = reg_addr_t'(take_bits(5));
            rd   = reg_addr_t'(take_bits(5));
            issue(encode_r(code, rs, rt, rd, '0));
            check_reg(rd);
        end
        for (int n = 0; n < 40; n++) begin
            code = I_OPS[int'(take_bits(3) % 7)];
            rs   = reg_addr_t'(take_bits(5));
            rt   = pick_reg();
            imm  = 16'(take_bits(16));
            issue(encode_i(code, rs, rt, imm));
            check_reg(rt);
        end
    endtask

    task automatic run_shifts();
        logic [5:0] fn;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        shamt_t     sa;
        for (int n = 0; n < 60; n++) begin
            fn = SH_FNS[int'(take_bits(3) % 6)];
            rs = reg_addr_t'(take_bits(5));
            rt = reg_addr_t'(take_bits(5));
            rd = pick_reg();
            sa = shamt_t'(take_bits(5));
            if (fn[2]) begin
                sa = '0;
            end else begin
                rs = '0;
            end
            issue(encode_r(fn, rs, rt, rd, sa));
            check_reg(rd);
        end
    endtask

    // Each link reads the previous destination through rs, rt or both
    task automatic run_chains();
        reg_addr_t  prev;
        reg_addr_t  other;
        reg_addr_t  dsts [6];
        logic [5:0] fn;
        int         mode;
        for (int c = 0; c < 8; c++) begin
            prev = pick_reg();
            for (int k = 0; k < 6; k++) begin
                dsts[k] = pick_reg();
                other   = reg_addr_t'(take_bits(5));
                fn      = R_FNS[int'(take_bits(3))];
                mode    = int'(take_bits(2) % 3);
                case (mode)
                    0:       issue(encode_r(fn, prev, other, dsts[k], '0));
                    1:       issue(encode_r(fn, other, prev, dsts[k], '0));
                    default: issue(encode_r(fn, prev, prev, dsts[k], '0));
                endcase
                prev = dsts[k];
            end
            for (int k = 0; k < 6; k++) begin
                check_reg(dsts[k]);
            end
        end
        check_all();
    endtask

    task automatic run_zero_and_unknown();
        reg_addr_t r;
        data_t     got;
        r = pick_reg();
        issue(encode_i(OP_ORI, r, 5'd0, 16'hbeef));
        issue(encode_r(FN_ADDU, r, r, 5'd0, '0));
        issue(encode_i(OP_LUI, 5'd0, 5'd0, 16'h1234));
        check_reg(5'd0);
        issue(encode_r(6'b011000, r, pick_reg(), '0, '0));     // MULT
        issue(encode_r(6'b001011, r, r, r, '0));               // MOVN
        issue(encode_r(6'b010000, '0, '0, r, '0));             // MFHI
        issue(encode_r(6'b001111, '0, '0, '0, '0));
        issue({6'b011100, r, r, r, 5'd0, 6'b100000});         // CLZ
        issue(encode_i(6'b110011, r, r, 16'h0040));
        issue(encode_i(6'b111111, r, r, 16'hffff));
        // Not the instruction address, so this valid ORI must not reach the decoder
        bus_access(1'b1, 6'd2, encode_i(OP_ORI, 5'd0, r, 16'h5a5a), got);
        bus_access(1'b0, 6'd1, ZERO_WORD, got);
        check_cnt++;
        assert (got == ZERO_WORD) else begin
            err_cnt++;
            $display("** Error at %0t: read of unmapped address 1 returned %h, expected 0",
                     $time, got);
        end
        check_all();
    endtask

    initial begin
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        rst_n_i  = 1'b0;
        for (int i = 0; i < 32; i++) begin
            shadow[i] = ZERO_WORD;
        end
        repeat (3) @(posedge clk_i);
        #2;
        rst_n_i = 1'b1;
        check_all();
        load_random_words();
        run_alu_ops();
        run_shifts();
        run_chains();
        run_zero_and_unknown();
        $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
